/* include/accCpu_config.svh */
`ifndef ACC_CPU_CONFIG_SVH
`define ACC_CPU_CONFIG_SVH

// --------------------
// instruction word layout
// --------------------
`define INSTR_W       16
`define OPCODE_W      6
`define OPERAND_W     10
// signed branch offset inside the operand
`define BR_OFF_W      6

// program counter and instruction store
`define INSTR_ADDR_W  10
`define INSTR_DEPTH   (1 << `INSTR_ADDR_W)

// accumulators and data store
`define DATA_W        8
`define DATA_ADDR_W   10
`define DATA_DEPTH    (1 << `DATA_ADDR_W)

// cycles allowed per program before the testbench gives up
`define CYCLE_LIMIT   200

`endif

/* src/accCpuPkg.sv */
`include "accCpu_config.svh"

package accCpuPkg;

	// --------------------
	// opcodes
	// --------------------
	// zero must stay NOP, unloaded store words decode as NOP
	// codes not listed here also behave as NOP
	typedef enum logic [`OPCODE_W-1:0] {
		NOP  = 6'd0,
		LDCA = 6'd1,
		LDCB = 6'd2,
		LDA  = 6'd3,
		LDB  = 6'd4,
		STA  = 6'd5,
		STB  = 6'd6,
		ADDA = 6'd7,
		ADDB = 6'd8,
		SUBA = 6'd9,
		SUBB = 6'd10,
		BEQ  = 6'd11,
		BNE  = 6'd12,
		JMP  = 6'd13,
		HALT = 6'd14
	} opcodeE;

	// --------------------
	// operand views
	// --------------------
	// constant view, value in the low byte
	typedef struct packed {
		logic [`OPERAND_W-`DATA_W-1:0] pad;
		logic [`DATA_W-1:0]            value;
	} immS;

	// relative branch view, offset counts from pc+1
	typedef struct packed {
		logic [`OPERAND_W-`BR_OFF_W-1:0] pad;
		logic signed [`BR_OFF_W-1:0]     offset;
	} brOffS;

	// one operand word, decoded per opcode
	typedef union packed {
		logic [`DATA_ADDR_W-1:0] addr;
		immS                     imm;
		brOffS                   br;
	} operandU;

	typedef struct packed {
		opcodeE  opcode;
		operandU operand;
	} instrS;

	// redirect from execute back to fetch
	typedef struct packed {
		logic                     taken;
		logic [`INSTR_ADDR_W-1:0] target;
	} branchS;

	// program load port, only used under reset
	typedef struct packed {
		logic                     en;
		logic [`INSTR_ADDR_W-1:0] addr;
		logic [`INSTR_W-1:0]      word;
	} progWriteS;

	// data memory write
	typedef struct packed {
		logic                    en;
		logic [`DATA_ADDR_W-1:0] addr;
		logic [`DATA_W-1:0]      data;
	} storeS;

	// visible machine state before the current instruction
	typedef struct packed {
		logic [`INSTR_ADDR_W-1:0] pc;
		logic [`DATA_W-1:0]       a;
		logic [`DATA_W-1:0]       b;
		logic                     halted;
	} archStateS;

endpackage

/* src/instrFetch.sv */
`timescale 1ns/10ps

`include "accCpu_config.svh"

module instrFetch (
	input  logic                     clk,
	input  logic                     reset,
	input  accCpuPkg::branchS        branch,
	output logic [`INSTR_ADDR_W-1:0] pc
);

	// candidate addresses
	logic [`INSTR_ADDR_W-1:0] pcSeq;
	logic [`INSTR_ADDR_W-1:0] pcNext;

	// --------------------
	// next address select
	// --------------------
	// sequential step, wraps at the top of the store
	assign pcSeq = pc + 1'b1;

	// taken redirect wins over the increment
	// halt arrives here as a branch to the current pc
	always_comb begin
		if (branch.taken) begin
			pcNext = branch.target;
		end else begin
			pcNext = pcSeq;
		end
	end

	// --------------------
	// pc register
	// --------------------
	// updates every edge, no stall input
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

/* src/instrMem.sv */
`timescale 1ns/10ps

`include "accCpu_config.svh"

module instrMem (
	input  logic                     clk,
	input  accCpuPkg::progWriteS     progWrite,
	input  logic [`INSTR_ADDR_W-1:0] pc,
	output accCpuPkg::instrS         instr
);

	// --------------------
	// storage
	// --------------------
	// all zero at start, so empty slots run as NOP
	logic [`INSTR_W-1:0] mem [`INSTR_DEPTH] = '{default: '0};

	// load port
	// words land at the edge while en is high
	// only driven during reset by whoever loads the program
	always_ff @(posedge clk) begin
		if (progWrite.en) begin
			mem[progWrite.addr] <= progWrite.word;
		end
	end

	// --------------------
	// fetch read
	// --------------------
	// no latency, execute sees the word in the same cycle as the pc
	assign instr = mem[pc];

endmodule

/* src/execUnit.sv */
`timescale 1ns/10ps

`include "accCpu_config.svh"

module execUnit (
	input  logic                     clk,
	input  logic                     reset,
	input  accCpuPkg::instrS         instr,
	input  logic [`INSTR_ADDR_W-1:0] pc,
	input  logic [`DATA_W-1:0]       rdData,
	output accCpuPkg::branchS        branch,
	output accCpuPkg::storeS         store,
	output accCpuPkg::archStateS     state
);

	// accumulators and halt flag
	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;
	logic               halted;

	// decoded fields
	accCpuPkg::opcodeE  op;
	accCpuPkg::operandU operand;

	// shared adder/subtractor
	logic               aluSub;
	logic [`DATA_W-1:0] aluX;
	logic [`DATA_W-1:0] aluY;
	logic [`DATA_W-1:0] aluOut;

	// next register values
	logic [`DATA_W-1:0] aNext;
	logic [`DATA_W-1:0] bNext;
	logic               haltNext;

	// branch helpers
	logic                     equal;
	logic [`INSTR_ADDR_W-1:0] pcPlusOne;
	logic [`INSTR_ADDR_W-1:0] brOffExt;
	logic [`INSTR_ADDR_W-1:0] brTarget;

	assign op      = instr.opcode;
	assign operand = instr.operand;

	// --------------------
	// alu
	// --------------------
	// SUBB is the only op with swapped inputs, B-A
	assign aluSub = (op == accCpuPkg::SUBA) || (op == accCpuPkg::SUBB);
	assign aluX   = (op == accCpuPkg::SUBB) ? b : a;
	assign aluY   = (op == accCpuPkg::SUBB) ? a : b;
	// 8 bit result, wraps mod 256
	assign aluOut = aluSub ? (aluX - aluY) : (aluX + aluY);

	// --------------------
	// register update
	// --------------------
	always_comb begin
		aNext    = a;
		bNext    = b;
		haltNext = halted;
		case (op)
			accCpuPkg::LDCA: aNext = operand.imm.value;
			accCpuPkg::LDCB: bNext = operand.imm.value;
			// memory read is combinational at operand.addr
			accCpuPkg::LDA: aNext = rdData;
			accCpuPkg::LDB: bNext = rdData;
			accCpuPkg::ADDA, accCpuPkg::SUBA: aNext = aluOut;
			accCpuPkg::ADDB, accCpuPkg::SUBB: bNext = aluOut;
			accCpuPkg::HALT: haltNext = 1'b1;
			// NOP, stores, branches and unknown codes leave A and B alone
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			a      <= '0;
			b      <= '0;
			halted <= 1'b0;
		end else begin
			a      <= aNext;
			b      <= bNext;
			halted <= haltNext;
		end
	end

	// --------------------
	// branch resolve
	// --------------------
	assign equal     = (a == b);
	assign pcPlusOne = pc + 1'b1;
	// sign extend the 6 bit offset to pc width
	assign brOffExt  = {{(`INSTR_ADDR_W - `BR_OFF_W){operand.br.offset[`BR_OFF_W-1]}},
		operand.br.offset};
	assign brTarget  = pcPlusOne + brOffExt;

	always_comb begin
		branch.taken  = 1'b0;
		branch.target = brTarget;
		case (op)
			accCpuPkg::BEQ: branch.taken = equal;
			accCpuPkg::BNE: branch.taken = !equal;
			// absolute, whole operand is the target
			accCpuPkg::JMP: begin
				branch.taken  = 1'b1;
				branch.target = operand.addr;
			end
			// spin on the HALT word, fetch needs no halt logic
			accCpuPkg::HALT: begin
				branch.taken  = 1'b1;
				branch.target = pc;
			end
			default: ;
		endcase
	end

	// --------------------
	// store and state out
	// --------------------
	// held off during reset so the program load cannot write data memory
	assign store.en   = ((op == accCpuPkg::STA) || (op == accCpuPkg::STB)) && !reset;
	assign store.addr = operand.addr;
	assign store.data = (op == accCpuPkg::STB) ? b : a;

	// values before the current instruction commits
	assign state.pc     = pc;
	assign state.a      = a;
	assign state.b      = b;
	assign state.halted = halted;

endmodule

/* src/dataMem.sv */
`timescale 1ns/10ps

`include "accCpu_config.svh"

module dataMem (
	input  logic                    clk,
	input  accCpuPkg::storeS        store,
	input  logic [`DATA_ADDR_W-1:0] rdAddr,
	output logic [`DATA_W-1:0]      rdData
);

	// --------------------
	// byte array
	// --------------------
	// zero at time zero, contents survive reset
	logic [`DATA_W-1:0] mem [`DATA_DEPTH] = '{default: '0};

	// write at the edge that commits STA or STB
	always_ff @(posedge clk) begin
		if (store.en) begin
			mem[store.addr] <= store.data;
		end
	end

	// async read
	// a load right after a store to the same address sees the new byte
	// one cycle later, since the write lands at the edge
	assign rdData = mem[rdAddr];

endmodule

/* src/accCpu.sv */
`timescale 1ns/10ps

`include "accCpu_config.svh"

module accCpu (
	input  logic                 clk,
	input  logic                 reset,
	input  accCpuPkg::progWriteS progWrite,
	output accCpuPkg::archStateS state,
	output accCpuPkg::storeS     store
);

	// --------------------
	// internal wires
	// --------------------
	logic [`INSTR_ADDR_W-1:0] pc;
	accCpuPkg::instrS         instr;
	accCpuPkg::branchS        branch;
	logic [`DATA_W-1:0]       rdData;

	// pc register and redirect
	instrFetch i_instrFetch (
		.clk    (clk),
		.reset  (reset),
		.branch (branch),
		.pc     (pc)
	);

	// program store, loaded under reset
	instrMem i_instrMem (
		.clk       (clk),
		.progWrite (progWrite),
		.pc        (pc),
		.instr     (instr)
	);

	// decode, accumulators, branch resolve
	execUnit i_execUnit (
		.clk    (clk),
		.reset  (reset),
		.instr  (instr),
		.pc     (pc),
		.rdData (rdData),
		.branch (branch),
		.store  (store),
		.state  (state)
	);

	// data store, read address straight from the operand
	dataMem i_dataMem (
		.clk    (clk),
		.store  (store),
		.rdAddr (instr.operand.addr),
		.rdData (rdData)
	);

endmodule

/* tb/tbAccCpu.sv */
`timescale 1ns/10ps

`include "accCpu_config.svh"

module tbAccCpu;

	localparam int PROG_LEN     = 32;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 40;
	localparam int NUM_TESTS    = NUM_RANDOM + 1;
	// every test loads, holds reset, then runs up to the limit; +2 for the first edge
	localparam int MAX_CYCLES   = NUM_TESTS * (`CYCLE_LIMIT + RESET_CYCLES + PROG_LEN) + 2;

	logic                 clk = 1'b0;
	logic                 reset;
	accCpuPkg::progWriteS progWrite;
	accCpuPkg::archStateS state;
	accCpuPkg::storeS     store;

	// --------------------
	// reference model state
	// --------------------
	logic [`INSTR_ADDR_W-1:0] mPc;
	logic [`DATA_W-1:0]       mA;
	logic [`DATA_W-1:0]       mB;
	logic                     mHalted;
	logic [`INSTR_W-1:0]      mImem [`INSTR_DEPTH] = '{default: '0};
	// survives between programs, like the DUT data store
	logic [`DATA_W-1:0]       mDmem [`DATA_DEPTH] = '{default: '0};
	logic                     expEn;
	logic [`DATA_ADDR_W-1:0]  expAddr;
	logic [`DATA_W-1:0]       expData;

	logic [`INSTR_W-1:0] prog [PROG_LEN];
	logic [31:0]         seed = 32'h5041;
	string               testName;
	int                  testErrors;
	int                  totalErrors = 0;
	int                  testsFailed = 0;
	int                  cycleCount = 0;

	accCpu i_accCpu (
		.clk       (clk),
		.reset     (reset),
		.progWrite (progWrite),
		.state     (state),
		.store     (store)
	);

	always #10 clk = ~clk;

	// run guard
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MAX_CYCLES) begin
			$display("timeout: simulation ran past %0d cycles without finishing", MAX_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	// --------------------
	// helpers
	// --------------------
	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic logic [`INSTR_W-1:0] encode(input logic [5:0] op, input logic [9:0] opnd);
		return {op, opnd};
	endfunction

	task automatic checkField(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("Error: %s %s expected %0h actual %0h", testName, field, expected, actual);
			testErrors++;
		end
	endtask

	// one ISA step from the opcode table, sets the expected store first
	task automatic stepModel();
		logic [`INSTR_W-1:0]      word;
		logic [5:0]               op;
		logic [9:0]               opnd;
		logic [`INSTR_ADDR_W-1:0] pcNext;
		word    = mImem[mPc];
		op      = word[15:10];
		opnd    = word[9:0];
		pcNext  = mPc + 10'd1;
		expEn   = 1'b0;
		expAddr = opnd;
		expData = (op == accCpuPkg::STB) ? mB : mA;
		case (op)
			accCpuPkg::LDCA: mA = opnd[7:0];
			accCpuPkg::LDCB: mB = opnd[7:0];
			accCpuPkg::LDA:  mA = mDmem[opnd];
			accCpuPkg::LDB:  mB = mDmem[opnd];
			accCpuPkg::STA, accCpuPkg::STB: begin
				expEn       = 1'b1;
				mDmem[opnd] = expData;
			end
			accCpuPkg::ADDA: mA = mA + mB;
			accCpuPkg::ADDB: mB = mA + mB;
			accCpuPkg::SUBA: mA = mA - mB;
			accCpuPkg::SUBB: mB = mB - mA;
			// relative to pc+1, 6 bit signed offset
			accCpuPkg::BEQ: if (mA == mB) pcNext = mPc + 10'd1 + {{4{opnd[5]}}, opnd[5:0]};
			accCpuPkg::BNE: if (mA != mB) pcNext = mPc + 10'd1 + {{4{opnd[5]}}, opnd[5:0]};
			accCpuPkg::JMP: pcNext = opnd;
			accCpuPkg::HALT: begin
				mHalted = 1'b1;
				pcNext  = mPc;
			end
			default: ;
		endcase
		mPc = pcNext;
	endtask

	// --------------------
	// programs
	// --------------------
	// wraparound, stores and loads, branches both ways, jump, halt
	task automatic makeDirectedProgram();
		foreach (prog[i]) prog[i] = '0;
		prog[0]  = encode(accCpuPkg::LDCA, 10'h0F0);
		prog[1]  = encode(accCpuPkg::LDCB, 10'h020);
		prog[2]  = encode(accCpuPkg::ADDA, 10'h000);
		prog[3]  = encode(accCpuPkg::SUBB, 10'h000);
		prog[4]  = encode(accCpuPkg::STA, 10'h003);
		prog[5]  = encode(accCpuPkg::SUBA, 10'h000);
		prog[6]  = encode(accCpuPkg::SUBA, 10'h000);
		prog[7]  = encode(accCpuPkg::STB, 10'h3FF);
		prog[8]  = encode(accCpuPkg::LDB, 10'h200);
		prog[9]  = encode(accCpuPkg::BNE, 10'h001);
		prog[10] = encode(accCpuPkg::HALT, 10'h000);
		prog[11] = encode(accCpuPkg::LDCA, 10'h30D);
		// loop 12..16 runs twice, the store changes what LDB reads back
		prog[12] = encode(accCpuPkg::LDCB, 10'h001);
		prog[13] = encode(accCpuPkg::STA, 10'h003);
		prog[14] = encode(accCpuPkg::LDA, 10'h3FF);
		prog[15] = encode(accCpuPkg::LDB, 10'h003);
		prog[16] = encode(accCpuPkg::BNE, 10'h3FB);
		prog[17] = encode(accCpuPkg::BEQ, 10'h001);
		prog[18] = encode(accCpuPkg::HALT, 10'h000);
		prog[19] = encode(accCpuPkg::JMP, 10'h015);
		prog[20] = encode(accCpuPkg::LDCA, 10'h0FF);
		prog[21] = encode(6'd45, 10'h2AA);
		prog[PROG_LEN-1] = encode(accCpuPkg::HALT, 10'h000);
	endtask

	task automatic makeRandomProgram();
		logic [31:0] r;
		logic [31:0] r2;
		logic [5:0]  op;
		logic [9:0]  opnd;
		int          pick;
		int          tgt;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			r    = nextRand();
			r2   = nextRand();
			pick = int'(r[31:16] % 18);
			// 0..13 defined, rest undefined codes 15..63
			op   = (pick < 14) ? pick[5:0] : 6'(15 + r[15:8] % 49);
			opnd = r2[25:16];
			tgt  = int'(r2[20:16]);
			case (op)
				accCpuPkg::LDA, accCpuPkg::LDB, accCpuPkg::STA, accCpuPkg::STB:
					if (r2[3:2] != 2'b00) opnd = {6'd0, r2[19:16]};
				// keep targets inside the 32 loaded words
				accCpuPkg::BEQ, accCpuPkg::BNE: opnd = {r2[29:26], 6'(tgt - i - 1)};
				accCpuPkg::JMP: opnd = {5'd0, r2[20:16]};
				default: ;
			endcase
			prog[i] = encode(op, opnd);
		end
		prog[PROG_LEN-1] = encode(accCpuPkg::HALT, 10'h000);
	endtask

	// --------------------
	// test runner
	// --------------------
	// called on a rising edge; load under reset, hold, then run and compare
	task automatic runProgram(input string name);
		int cyc;
		int afterHalt;
		testName   = name;
		testErrors = 0;
		reset <= 1'b1;
		for (int i = 0; i < PROG_LEN; i++) begin
			progWrite.en   <= 1'b1;
			progWrite.addr <= i[`INSTR_ADDR_W-1:0];
			progWrite.word <= prog[i];
			mImem[i] = prog[i];
			@(posedge clk);
		end
		progWrite.en <= 1'b0;
		mPc     = '0;
		mA      = '0;
		mB      = '0;
		mHalted = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			checkField("store.en in reset", 32'd0, 32'(store.en));
			@(posedge clk);
		end
		reset <= 1'b0;
		cyc       = 0;
		afterHalt = 0;
		// sampled mid-cycle, the next rising edge commits the instruction
		while (cyc < `CYCLE_LIMIT && afterHalt < 3) begin
			@(negedge clk);
			checkField("pc", 32'(mPc), 32'(state.pc));
			checkField("a", 32'(mA), 32'(state.a));
			checkField("b", 32'(mB), 32'(state.b));
			checkField("halted", 32'(mHalted), 32'(state.halted));
			stepModel();
			checkField("store.en", 32'(expEn), 32'(store.en));
			if (expEn) begin
				checkField("store.addr", 32'(expAddr), 32'(store.addr));
				checkField("store.data", 32'(expData), 32'(store.data));
			end
			if (mHalted) afterHalt++;
			cyc++;
			@(posedge clk);
		end
		totalErrors += testErrors;
		if (testErrors != 0) testsFailed++;
		$display("test %s: %0d cycles, %s, %0d errors", name, cyc,
			mHalted ? "halted" : "cycle limit", testErrors);
	endtask

	initial begin
		reset     = 1'b1;
		progWrite = '0;
		@(posedge clk);
		makeDirectedProgram();
		runProgram("directed");
		for (int t = 0; t < NUM_RANDOM; t++) begin
			makeRandomProgram();
			runProgram($sformatf("random_%02d", t));
		end
		$display("%0d tests, %0d failed, %0d errors", NUM_TESTS, testsFailed, totalErrors);
		if (totalErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* accCpu.f */
+incdir+include
src/accCpuPkg.sv
src/instrFetch.sv
src/instrMem.sv
src/execUnit.sv
src/dataMem.sv
src/accCpu.sv
tb/tbAccCpu.sv

/* Makefile */
# Verilator build and run for the accumulator CPU testbench

VERILATOR ?= verilator
TOP       ?= tbAccCpu
FILELIST  ?= accCpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Done: no errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q -x "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
